/* logic/mips_pkg.sv */
// shared types and encodings for the five-stage MIPS core
// every RTL file of the core imports this package by wildcard

package mips_pkg;

    localparam int WORD_W   = 32;
    localparam int REG_W    = 5;
    localparam int NUM_REGS = 32;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [REG_W-1:0]  reg_addr_t;

    localparam word_t RESET_PC = 32'd0;    // word address, pc counts in words

    // *******************************************************************
    // instruction encodings
    // *******************************************************************

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;

    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_SLL, ALU_SRL, ALU_LUI
    } alu_op_e;

    // source of an execute operand
    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,
        FWD_MEM  = 2'b01,
        FWD_WB   = 2'b10
    } fwd_sel_e;

    // *******************************************************************
    // pipeline boundary words
    // *******************************************************************

    typedef struct packed {
        logic    reg_write;
        logic    reg_dst;     // 1: rd, 0: rt
        logic    alu_src;     // 1: immediate operand
        alu_op_e alu_op;
        logic    mem_write;
        logic    mem_to_reg;
    } ctrl_t;

    typedef struct packed {
        word_t pc_next;
        word_t instr;
    } fetch_decode_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     rs_data;
        word_t     rt_data;
        word_t     sign_imm;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        reg_addr_t shamt;
    } decode_execute_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t write_reg;
    } execute_memory_t;

    typedef struct packed {
        logic      reg_write;
        logic      mem_to_reg;
        word_t     alu_result;
        word_t     read_data;
        reg_addr_t write_reg;
    } memory_writeback_t;

endpackage

/* logic/fetch_stage.sv */
// fetch stage, holds the pc and the fetch-to-decode register
// branches resolved in decode redirect the pc with no delay slot

`timescale 1ns/1ns

module fetch_stage
    import mips_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          stall,
    input  logic          branch_taken,
    input  word_t         branch_target,
    output word_t         im_addr,
    input  word_t         im_data,
    output fetch_decode_t fd,
    output word_t         pc
);

    word_t pc_next;

    assign pc_next = pc + 32'd1;   // one word per instruction
    assign im_addr = pc;

    always_ff @(posedge clk) begin
        if (reset)
            pc <= RESET_PC;
        else if (!stall)
            pc <= branch_taken ? branch_target : pc_next;
    end

    // a taken branch squashes the slot just fetched
    always_ff @(posedge clk) begin
        if (reset || (branch_taken && !stall))
            fd <= '0;               // instr 0 decodes as a no-op
        else if (!stall)
            fd <= '{pc_next: pc_next, instr: im_data};
    end

    pc_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(pc))
        else $error("fetch pc is unknown");

endmodule

/* logic/register_file.sv */
// 32-entry register file with two operand ports and a debug port
// writes land on the rising edge and are visible to reads in the same cycle

`timescale 1ns/1ns

module register_file
    import mips_pkg::*;
(
    input  logic      clk,
    input  reg_addr_t ra1,
    input  reg_addr_t ra2,
    input  reg_addr_t ra_dbg,
    output word_t     rd1,
    output word_t     rd2,
    output word_t     rd_dbg,
    input  logic      we,
    input  reg_addr_t wa,
    input  word_t     wd,
    input  word_t     pc      // debug view of register 0
);

    word_t regs [NUM_REGS];

    function automatic word_t read_reg(reg_addr_t a);
        if (a == '0)
            return '0;
        if (we && a == wa)
            return wd;        // write-through
        return regs[a];
    endfunction

    always_ff @(posedge clk) begin
        if (we && wa != '0)
            regs[wa] <= wd;
    end

    always_comb begin
        rd1    = read_reg(ra1);
        rd2    = read_reg(ra2);
        rd_dbg = (ra_dbg == '0) ? pc : read_reg(ra_dbg);
    end

endmodule

/* logic/control_unit.sv */
// main decoder, maps opcode and funct onto the pipeline control word
// beq and bne are decided here from the decode-stage compare

`timescale 1ns/1ns

module control_unit
    import mips_pkg::*;
(
    input  logic [5:0] opcode,
    input  logic [5:0] funct,
    input  logic       regs_equal,
    output ctrl_t      ctrl,
    output logic       is_branch,
    output logic       branch_taken
);

    always_comb begin
        ctrl         = '0;    // unknown encodings fall through as no-ops
        is_branch    = 1'b0;
        branch_taken = 1'b0;

        case (opcode)
            OP_SPECIAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst   = 1'b1;
                case (funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    FN_SLL:  ctrl.alu_op = ALU_SLL;
                    FN_SRL:  ctrl.alu_op = ALU_SRL;
                    default: ctrl = '0;
                endcase
            end
            OP_ADDIU: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = ALU_ADD;
            end
            OP_LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = ALU_LUI;
            end
            OP_LW: begin
                ctrl.reg_write  = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.mem_to_reg = 1'b1;    // address from the adder
            end
            OP_SW: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            OP_BEQ: begin
                is_branch    = 1'b1;
                branch_taken = regs_equal;
            end
            OP_BNE: begin
                is_branch    = 1'b1;
                branch_taken = !regs_equal;
            end
            default: ;
        endcase
    end

endmodule

/* logic/decode_stage.sv */
// decode stage, splits the instruction and resolves branches early
// the compare takes memory-stage results through fwd_branch_a/b

`timescale 1ns/1ns

module decode_stage
    import mips_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic            stall,
    input  fetch_decode_t   fd,
    input  word_t           rd1,
    input  word_t           rd2,
    input  word_t           mem_alu_result,
    input  logic            fwd_branch_a,
    input  logic            fwd_branch_b,
    output reg_addr_t       rs,
    output reg_addr_t       rt,
    output logic            is_branch,
    output logic            branch_taken,
    output word_t           branch_target,
    output decode_execute_t de
);

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rd;
    reg_addr_t  shamt;
    word_t      sign_imm;
    word_t      cmp_a;
    word_t      cmp_b;
    ctrl_t      ctrl;

    // instruction fields
    assign opcode   = fd.instr[31:26];
    assign rs       = fd.instr[25:21];
    assign rt       = fd.instr[20:16];
    assign rd       = fd.instr[15:11];
    assign shamt    = fd.instr[10:6];
    assign funct    = fd.instr[5:0];
    assign sign_imm = {{16{fd.instr[15]}}, fd.instr[15:0]};

    assign branch_target = fd.pc_next + sign_imm;   // word offset

    assign cmp_a = fwd_branch_a ? mem_alu_result : rd1;
    assign cmp_b = fwd_branch_b ? mem_alu_result : rd2;

    control_unit control_unit_inst (
        .opcode       (opcode),
        .funct        (funct),
        .regs_equal   (cmp_a == cmp_b),
        .ctrl         (ctrl),
        .is_branch    (is_branch),
        .branch_taken (branch_taken)
    );

    // *******************************************************************
    // decode-to-execute register
    // *******************************************************************

    always_ff @(posedge clk) begin
        if (reset || stall)
            de.ctrl <= '0;    // bubble into execute
        else
            de.ctrl <= ctrl;
    end

    always_ff @(posedge clk) begin
        de.rs_data  <= rd1;   // forwarding is redone in execute
        de.rt_data  <= rd2;
        de.sign_imm <= sign_imm;
        de.rs       <= rs;
        de.rt       <= rt;
        de.rd       <= rd;
        de.shamt    <= shamt;
    end

endmodule

/* logic/execute_stage.sv */
// execute stage, forwards operands, runs the ALU and picks the destination
// results go to the execute-to-memory register

`timescale 1ns/1ns

module execute_stage
    import mips_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  decode_execute_t de,
    input  fwd_sel_e        fwd_a,
    input  fwd_sel_e        fwd_b,
    input  word_t           mem_alu_result,
    input  word_t           wb_data,
    output reg_addr_t       write_reg,
    output execute_memory_t em
);

    word_t src_a;
    word_t src_b;
    word_t store_data;
    word_t alu_result;

    always_comb begin
        case (fwd_a)
            FWD_MEM: src_a = mem_alu_result;
            FWD_WB:  src_a = wb_data;
            default: src_a = de.rs_data;
        endcase
        case (fwd_b)
            FWD_MEM: store_data = mem_alu_result;
            FWD_WB:  store_data = wb_data;
            default: store_data = de.rt_data;
        endcase
    end

    assign src_b = de.ctrl.alu_src ? de.sign_imm : store_data;

    always_comb begin
        case (de.ctrl.alu_op)
            ALU_ADD: alu_result = src_a + src_b;
            ALU_SUB: alu_result = src_a - src_b;
            ALU_AND: alu_result = src_a & src_b;
            ALU_OR:  alu_result = src_a | src_b;
            ALU_SLT: alu_result = {31'd0, $signed(src_a) < $signed(src_b)};
            ALU_SLL: alu_result = src_b << de.shamt;   // shifts act on rt
            ALU_SRL: alu_result = src_b >> de.shamt;
            default: alu_result = {src_b[15:0], 16'd0}; // lui
        endcase
    end

    assign write_reg = de.ctrl.reg_dst ? de.rd : de.rt;

    always_ff @(posedge clk) begin
        if (reset)
            em.ctrl <= '0;
        else
            em.ctrl <= de.ctrl;
    end

    always_ff @(posedge clk) begin
        em.alu_result <= alu_result;
        em.store_data <= store_data;
        em.write_reg  <= write_reg;
    end

    // register 0 is hardwired, the hazard unit must never bypass into it
    no_fwd_r0: assert property (@(posedge clk) disable iff (reset)
        ((de.rs == '0) -> (fwd_a == FWD_NONE)) && ((de.rt == '0) -> (fwd_b == FWD_NONE)))
        else $error("forwarding selected for register 0");

endmodule

/* logic/memory_stage.sv */
// memory stage, drives the data memory port and the writeback register
// the writeback select sits after the memory-to-writeback register

`timescale 1ns/1ns

module memory_stage
    import mips_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  execute_memory_t em,
    output word_t           dm_addr,
    output word_t           dm_wdata,
    output logic            dm_we,
    input  word_t           dm_rdata,
    output logic            wb_we,
    output reg_addr_t       wb_reg,
    output word_t           wb_data
);

    memory_writeback_t mw;

    assign dm_addr  = em.alu_result;
    assign dm_wdata = em.store_data;
    assign dm_we    = em.ctrl.mem_write;

    always_ff @(posedge clk) begin
        if (reset) begin
            mw.reg_write  <= 1'b0;
            mw.mem_to_reg <= 1'b0;
        end else begin
            mw.reg_write  <= em.ctrl.reg_write;
            mw.mem_to_reg <= em.ctrl.mem_to_reg;
        end
    end

    always_ff @(posedge clk) begin
        mw.alu_result <= em.alu_result;
        mw.read_data  <= dm_rdata;
        mw.write_reg  <= em.write_reg;
    end

    // writeback
    assign wb_we   = mw.reg_write;
    assign wb_reg  = mw.write_reg;
    assign wb_data = mw.mem_to_reg ? mw.read_data : mw.alu_result;

endmodule

/* logic/hazard_unit.sv */
// hazard detection and the forwarding selects for execute and the branch compare
// stalls hold fetch and decode and insert a bubble into execute

`timescale 1ns/1ns

module hazard_unit
    import mips_pkg::*;
(
    input  reg_addr_t rs_d,
    input  reg_addr_t rt_d,
    input  reg_addr_t rs_e,
    input  reg_addr_t rt_e,
    input  reg_addr_t write_reg_e,
    input  reg_addr_t write_reg_m,
    input  reg_addr_t write_reg_w,
    input  ctrl_t     ctrl_e,
    input  ctrl_t     ctrl_m,
    input  logic      reg_write_w,
    input  logic      is_branch,
    output logic      stall,
    output fwd_sel_e  fwd_a,
    output fwd_sel_e  fwd_b,
    output logic      fwd_branch_a,
    output logic      fwd_branch_b
);

    logic load_use;
    logic branch_dep;

    // memory stage wins over writeback as it holds the younger result
    function automatic fwd_sel_e pick(reg_addr_t src);
        if (src == '0)
            return FWD_NONE;
        if (ctrl_m.reg_write && src == write_reg_m)
            return FWD_MEM;
        if (reg_write_w && src == write_reg_w)
            return FWD_WB;
        return FWD_NONE;
    endfunction

    always_comb begin
        fwd_a = pick(rs_e);
        fwd_b = pick(rt_e);
    end

    assign fwd_branch_a = rs_d != '0 && ctrl_m.reg_write && rs_d == write_reg_m;
    assign fwd_branch_b = rt_d != '0 && ctrl_m.reg_write && rt_d == write_reg_m;

    assign load_use = ctrl_e.mem_to_reg && (rs_d == write_reg_e || rt_d == write_reg_e);

    // compare needs the value before execute or a load has finished
    assign branch_dep = is_branch &&
        ((ctrl_e.reg_write && (rs_d == write_reg_e || rt_d == write_reg_e)) ||
         (ctrl_m.mem_to_reg && (rs_d == write_reg_m || rt_d == write_reg_m)));

    assign stall = load_use || branch_dep;

    // a load in memory only has its address so execute must never take its bypass
    always_comb begin
        no_load_addr_fwd: assert final (!(ctrl_m.mem_to_reg && ctrl_e != '0 &&
                                          (fwd_a == FWD_MEM || fwd_b == FWD_MEM)))
            else $error("execute operand forwarded from a load in memory");
    end

endmodule

/* logic/mips_pipeline.sv */
// top of the five-stage pipelined MIPS core
// memories sit outside and answer combinationally, register 0 on the debug port reads the pc

`timescale 1ns/1ns

module mips_pipeline
    import mips_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    output word_t     im_addr,
    input  word_t     im_data,
    output word_t     dm_addr,
    output logic      dm_we,
    output word_t     dm_wdata,
    input  word_t     dm_rdata,
    input  reg_addr_t reg_addr,
    output word_t     reg_data
);

    fetch_decode_t   fd;
    decode_execute_t de;
    execute_memory_t em;

    word_t     pc;
    word_t     rd1;
    word_t     rd2;
    word_t     branch_target;
    word_t     wb_data;
    reg_addr_t rs_d;
    reg_addr_t rt_d;
    reg_addr_t write_reg_e;
    reg_addr_t wb_reg;
    logic      wb_we;
    logic      stall;
    logic      is_branch;
    logic      branch_taken;
    logic      fwd_branch_a;
    logic      fwd_branch_b;
    fwd_sel_e  fwd_a;
    fwd_sel_e  fwd_b;

    // *******************************************************************
    // stages
    // *******************************************************************

    fetch_stage fetch_stage_inst (
        .clk           (clk),
        .reset         (reset),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .im_addr       (im_addr),
        .im_data       (im_data),
        .fd            (fd),
        .pc            (pc)
    );

    register_file register_file_inst (
        .clk    (clk),
        .ra1    (rs_d),
        .ra2    (rt_d),
        .ra_dbg (reg_addr),
        .rd1    (rd1),
        .rd2    (rd2),
        .rd_dbg (reg_data),
        .we     (wb_we),
        .wa     (wb_reg),
        .wd     (wb_data),
        .pc     (pc)
    );

    decode_stage decode_stage_inst (
        .clk            (clk),
        .reset          (reset),
        .stall          (stall),
        .fd             (fd),
        .rd1            (rd1),
        .rd2            (rd2),
        .mem_alu_result (em.alu_result),
        .fwd_branch_a   (fwd_branch_a),
        .fwd_branch_b   (fwd_branch_b),
        .rs             (rs_d),
        .rt             (rt_d),
        .is_branch      (is_branch),
        .branch_taken   (branch_taken),
        .branch_target  (branch_target),
        .de             (de)
    );

    execute_stage execute_stage_inst (
        .clk            (clk),
        .reset          (reset),
        .de             (de),
        .fwd_a          (fwd_a),
        .fwd_b          (fwd_b),
        .mem_alu_result (em.alu_result),
        .wb_data        (wb_data),
        .write_reg      (write_reg_e),
        .em             (em)
    );

    memory_stage memory_stage_inst (
        .clk      (clk),
        .reset    (reset),
        .em       (em),
        .dm_addr  (dm_addr),
        .dm_wdata (dm_wdata),
        .dm_we    (dm_we),
        .dm_rdata (dm_rdata),
        .wb_we    (wb_we),
        .wb_reg   (wb_reg),
        .wb_data  (wb_data)
    );

    // *******************************************************************
    // hazards
    // *******************************************************************

    hazard_unit hazard_unit_inst (
        .rs_d         (rs_d),
        .rt_d         (rt_d),
        .rs_e         (de.rs),
        .rt_e         (de.rt),
        .write_reg_e  (write_reg_e),
        .write_reg_m  (em.write_reg),
        .write_reg_w  (wb_reg),
        .ctrl_e       (de.ctrl),
        .ctrl_m       (em.ctrl),
        .reg_write_w  (wb_we),
        .is_branch    (is_branch),
        .stall        (stall),
        .fwd_a        (fwd_a),
        .fwd_b        (fwd_b),
        .fwd_branch_a (fwd_branch_a),
        .fwd_branch_b (fwd_branch_b)
    );

endmodule

/* sim/tb_mips_pipeline.sv */
// testbench for the pipelined MIPS core that runs small programs against an ISA model
// memories live here and results are read back through the debug register port

`timescale 1ns/1ns

module tb_mips_pipeline
    import mips_pkg::*;
();

    localparam int    NUM_PROGS    = 5;
    localparam int    DRAIN_CYCLES = 8;    // enough for the last instruction to retire
    localparam word_t HALT         = {OP_BEQ, 5'd0, 5'd0, 16'hffff};   // self-branch

    logic      clk;
    logic      reset;
    word_t     im_addr;
    word_t     im_data;
    word_t     dm_addr;
    word_t     dm_wdata;
    word_t     dm_rdata;
    logic      dm_we;
    reg_addr_t reg_addr;
    word_t     reg_data;

    word_t       imem [256];
    word_t       dmem [256];
    word_t       model_regs [NUM_REGS];
    word_t       model_mem [256];
    logic [63:0] exp_stores [$];           // {address, data}
    logic [63:0] got_stores [$];

    word_t code [1024];
    int    prog_start [NUM_PROGS];
    int    prog_len [NUM_PROGS];
    int    code_len;
    int    total_len;
    int    value_errors;
    int    other_errors;
    int    seed;

    mips_pipeline mips_pipeline_inst (
        .clk      (clk),
        .reset    (reset),
        .im_addr  (im_addr),
        .im_data  (im_data),
        .dm_addr  (dm_addr),
        .dm_we    (dm_we),
        .dm_wdata (dm_wdata),
        .dm_rdata (dm_rdata),
        .reg_addr (reg_addr),
        .reg_data (reg_data)
    );

    always #5 clk = ~clk;

    // *******************************************************************
    // memory models
    // *******************************************************************

    assign im_data  = imem[im_addr[7:0]];
    assign dm_rdata = dmem[dm_addr[7:0]];

    always @(posedge clk) begin
        if (dm_we === 1'b1)
            dmem[dm_addr[7:0]] <= dm_wdata;
    end

    // store monitor sampled away from the rising edge
    always @(negedge clk) begin
        if (reset === 1'b0 && dm_we === 1'b1)
            got_stores.push_back({dm_addr, dm_wdata});
    end

    function automatic word_t fill_word(int addr);
        return 32'hd0000000 + addr * 32'h00010001;
    endfunction

    function automatic word_t r_op(logic [5:0] fn, reg_addr_t rd, reg_addr_t rs,
                                   reg_addr_t rt, logic [4:0] sh);
        return {OP_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t i_op(logic [5:0] op, reg_addr_t rt, reg_addr_t rs,
                                   logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // *******************************************************************
    // ISA reference model without timing that stops at the first taken self-branch
    // *******************************************************************

    function automatic word_t run_model();
        word_t      pc;
        word_t      ins;
        word_t      a;
        word_t      b;
        word_t      imm;
        word_t      val;
        logic [5:0] op;
        reg_addr_t  dst;
        logic       wr;
        pc = RESET_PC;
        for (int steps = 0; steps < 1000; steps++) begin
            ins = imem[pc[7:0]];
            op  = ins[31:26];
            a   = model_regs[ins[25:21]];
            b   = model_regs[ins[20:16]];
            imm = {{16{ins[15]}}, ins[15:0]};
            pc  = pc + 1;
            wr  = 1'b1;
            dst = ins[20:16];
            val = '0;
            case (op)
                OP_SPECIAL: begin
                    dst = ins[15:11];
                    case (ins[5:0])
                        FN_ADDU: val = a + b;
                        FN_SUBU: val = a - b;
                        FN_AND:  val = a & b;
                        FN_OR:   val = a | b;
                        FN_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        FN_SLL:  val = b << ins[10:6];
                        FN_SRL:  val = b >> ins[10:6];
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDIU: val = a + imm;
                OP_LUI:   val = {ins[15:0], 16'h0000};
                OP_LW:    val = model_mem[(a + imm) & 32'hff];
                OP_SW: begin
                    wr = 1'b0;
                    model_mem[(a + imm) & 32'hff] = b;
                    exp_stores.push_back({a + imm, b});
                end
                OP_BEQ, OP_BNE: begin
                    wr = 1'b0;
                    if ((a == b) == (op == OP_BEQ)) begin
                        if (imm == 32'hffffffff)
                            return pc - 1;     // halted on the self-branch
                        pc = pc + imm;
                    end
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != '0)
                model_regs[dst] = val;
        end
        other_errors++;
        $display("reference model never reached a self-branch");
        return pc;
    endfunction

    // *******************************************************************
    // checks
    // *******************************************************************

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic confirm_reset(input string name);
        check_value({name, " reset im_addr"}, RESET_PC, im_addr);
        check_value({name, " reset dm_we"}, 32'd0, {31'd0, dm_we});
    endtask

    task automatic compare_state(input string name, input word_t end_pc);
        @(negedge clk);
        reg_addr = '0;                    // debug r0 shows the fetch pc
        while (im_addr !== end_pc)        // the halt loop also fetches end_pc + 1
            @(negedge clk);
        #1;
        check_value({name, " r0"}, end_pc, reg_data);
        for (int r = 1; r < NUM_REGS; r++) begin
            @(negedge clk);
            reg_addr = reg_addr_t'(r);
            #1;
            check_value($sformatf("%s r%0d", name, r), model_regs[r], reg_data);
        end
        check_value({name, " store count"}, exp_stores.size(), got_stores.size());
        for (int s = 0; s < exp_stores.size() && s < got_stores.size(); s++) begin
            check_value($sformatf("%s store %0d addr", name, s), exp_stores[s][63:32],
                        got_stores[s][63:32]);
            check_value($sformatf("%s store %0d data", name, s), exp_stores[s][31:0],
                        got_stores[s][31:0]);
        end
    endtask

    // *******************************************************************
    // programs
    // *******************************************************************

    task automatic emit(input word_t ins);
        code[code_len] = ins;
        code_len++;
    endtask

    task automatic open_program(input int p);
        prog_start[p] = code_len;
    endtask

    task automatic close_program(input int p);
        emit(HALT);
        prog_len[p] = code_len - prog_start[p];
    endtask

    task automatic build_programs();
        word_t rnd;
        word_t ins;
        // clear every register since the file has no reset
        open_program(0);
        for (int i = 1; i < NUM_REGS; i++)
            emit(i_op(OP_ADDIU, reg_addr_t'(i), 5'd0, 16'd0));
        close_program(0);

        open_program(1);                                   // dependent ALU chain
        emit(i_op(OP_ADDIU, 5'd1, 5'd0, 16'd5));
        emit(i_op(OP_ADDIU, 5'd2, 5'd1, 16'd7));
        emit(r_op(FN_ADDU, 5'd3, 5'd1, 5'd2, 5'd0));
        emit(r_op(FN_SUBU, 5'd4, 5'd3, 5'd1, 5'd0));
        emit(r_op(FN_AND,  5'd5, 5'd4, 5'd3, 5'd0));
        emit(r_op(FN_OR,   5'd6, 5'd5, 5'd4, 5'd0));
        emit(r_op(FN_SLT,  5'd7, 5'd6, 5'd5, 5'd0));
        emit(r_op(FN_SLT,  5'd8, 5'd5, 5'd6, 5'd0));
        emit(r_op(FN_SLL,  5'd9, 5'd0, 5'd3, 5'd4));
        emit(r_op(FN_SRL,  5'd10, 5'd0, 5'd9, 5'd2));
        emit(i_op(OP_LUI,  5'd11, 5'd0, 16'h8001));
        emit(r_op(FN_SLT,  5'd12, 5'd11, 5'd10, 5'd0));   // negative below positive
        emit(r_op(FN_ADDU, 5'd13, 5'd12, 5'd11, 5'd0));
        close_program(1);

        open_program(2);                                   // stores, loads, load-use
        emit(i_op(OP_ADDIU, 5'd1, 5'd0, 16'd16));
        emit(i_op(OP_ADDIU, 5'd2, 5'd0, 16'h1234));
        emit(i_op(OP_SW, 5'd2, 5'd1, 16'd0));
        emit(i_op(OP_SW, 5'd1, 5'd1, 16'd4));
        emit(i_op(OP_LW, 5'd3, 5'd1, 16'd0));
        emit(r_op(FN_ADDU, 5'd4, 5'd3, 5'd2, 5'd0));
        emit(i_op(OP_LW, 5'd5, 5'd1, 16'd4));
        emit(i_op(OP_SW, 5'd5, 5'd1, 16'd8));            // store data right after load
        emit(i_op(OP_LW, 5'd6, 5'd1, 16'd8));
        emit(i_op(OP_ADDIU, 5'd7, 5'd6, 16'd1));
        close_program(2);

        open_program(3);                                   // early branches
        emit(i_op(OP_ADDIU, 5'd1, 5'd0, 16'd3));
        emit(i_op(OP_ADDIU, 5'd2, 5'd0, 16'd3));
        emit(i_op(OP_BEQ, 5'd2, 5'd1, 16'd2));           // taken with ALU one back
        emit(i_op(OP_ADDIU, 5'd10, 5'd0, 16'd99));       // skipped
        emit(i_op(OP_SW, 5'd1, 5'd0, 16'd0));            // skipped
        emit(i_op(OP_BNE, 5'd2, 5'd1, 16'd2));           // not taken
        emit(i_op(OP_ADDIU, 5'd3, 5'd0, 16'd7));
        emit(i_op(OP_LW, 5'd4, 5'd0, 16'd16));
        emit(i_op(OP_BEQ, 5'd3, 5'd4, 16'd1));           // load one back and not taken
        emit(i_op(OP_ADDIU, 5'd5, 5'd0, 16'd1));
        emit(i_op(OP_LW, 5'd6, 5'd0, 16'd16));
        emit(i_op(OP_ADDIU, 5'd7, 5'd0, 16'd0));
        emit(i_op(OP_BNE, 5'd0, 5'd6, 16'd2));           // taken with load two back
        emit(i_op(OP_ADDIU, 5'd11, 5'd0, 16'd1));        // skipped
        emit(i_op(OP_SW, 5'd6, 5'd0, 16'd1));            // skipped
        emit(r_op(FN_ADDU, 5'd8, 5'd1, 5'd2, 5'd0));
        emit(i_op(OP_ADDIU, 5'd9, 5'd0, 16'd6));
        emit(i_op(OP_BEQ, 5'd9, 5'd8, 16'd1));           // taken with ALU one and two back
        emit(i_op(OP_ADDIU, 5'd12, 5'd0, 16'd5));        // skipped
        close_program(3);

        open_program(4);                                   // random without branches
        for (int i = 0; i < 40; i++) begin
            rnd = $random(seed);
            case ($unsigned($random(seed)) % 11)
                0:  ins = r_op(FN_ADDU, rnd[2:0], rnd[5:3], rnd[8:6], 5'd0);
                1:  ins = r_op(FN_SUBU, rnd[2:0], rnd[5:3], rnd[8:6], 5'd0);
                2:  ins = r_op(FN_AND,  rnd[2:0], rnd[5:3], rnd[8:6], 5'd0);
                3:  ins = r_op(FN_OR,   rnd[2:0], rnd[5:3], rnd[8:6], 5'd0);
                4:  ins = r_op(FN_SLT,  rnd[2:0], rnd[5:3], rnd[8:6], 5'd0);
                5:  ins = r_op(FN_SLL,  rnd[2:0], 5'd0, rnd[8:6], rnd[13:9]);
                6:  ins = r_op(FN_SRL,  rnd[2:0], 5'd0, rnd[8:6], rnd[13:9]);
                7:  ins = i_op(OP_ADDIU, rnd[2:0], rnd[5:3], rnd[31:16]);
                8:  ins = i_op(OP_LUI,   rnd[2:0], 5'd0, rnd[31:16]);
                9:  ins = i_op(OP_LW,    rnd[2:0], rnd[5:3], rnd[31:16]);
                default: ins = i_op(OP_SW, rnd[2:0], rnd[5:3], rnd[31:16]);
            endcase
            emit(ins);
        end
        close_program(4);
    endtask

    task automatic run_program(input string name, input int p);
        word_t end_pc;
        @(negedge clk);
        reset = 1'b1;                 // stop the old program before the swap
        got_stores.delete();
        exp_stores.delete();
        for (int i = 0; i < 256; i++)
            imem[i] = (i < prog_len[p]) ? code[prog_start[p] + i] : '0;
        end_pc = run_model();
        repeat (3) begin
            @(negedge clk);
            confirm_reset(name);
        end
        reset = 1'b0;
        #1;
        confirm_reset(name);          // first cycle out of reset
        while (im_addr !== end_pc)
            @(negedge clk);
        repeat (DRAIN_CYCLES) @(negedge clk);
        compare_state(name, end_pc);
    endtask

    // *******************************************************************
    // main sequence and watchdog
    // *******************************************************************

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        reg_addr     = '0;
        value_errors = 0;
        other_errors = 0;
        code_len     = 0;
        total_len    = 0;
        seed         = 1967;
        for (int i = 0; i < 256; i++) begin
            imem[i]      = '0;
            dmem[i]      = fill_word(i);
            model_mem[i] = fill_word(i);
        end
        for (int r = 0; r < NUM_REGS; r++)
            model_regs[r] = '0;
        build_programs();
        total_len = code_len;
        run_program("init", 0);
        run_program("alu chain", 1);
        run_program("memory", 2);
        run_program("branches", 3);
        run_program("random", 4);
        $display("%0d value mismatches, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    initial begin
        wait (total_len > 0);
        repeat (total_len * 4 + 100) @(posedge clk);
        other_errors++;
        $display("watchdog expired before the last program finished");
        $display("%0d value mismatches, %0d other errors", value_errors, other_errors);
        $display("tests failed");
        $finish;
    end

endmodule

/* src.f */
logic/mips_pkg.sv
logic/fetch_stage.sv
logic/register_file.sv
logic/control_unit.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/hazard_unit.sv
logic/mips_pipeline.sv
sim/tb_mips_pipeline.sv

/* Bender.yml */
package:
  name: mips_pipeline

sources:
  - logic/mips_pkg.sv
  - logic/fetch_stage.sv
  - logic/register_file.sv
  - logic/control_unit.sv
  - logic/decode_stage.sv
  - logic/execute_stage.sv
  - logic/memory_stage.sv
  - logic/hazard_unit.sv
  - logic/mips_pipeline.sv
  - target: simulation
    files:
      - sim/tb_mips_pipeline.sv
